//--- client_arbiter.sv
`default_nettype none

module client_arbiter
	import client_pkg::*;
(
	input  wire                                CLK,
	input  wire                                RST,
	input  wire [NUM_CLIENTS-1:0]              reqs,
	input  wire client_req_t [NUM_CLIENTS-1:0] client_reqs,
	input  wire                                latched,
	output logic                               do_act,
	output client_req_t                        sel_req,
	output client_id_t                         grant,
	output logic [NUM_CLIENTS-1:0]             latched_out
);

	client_id_t prio;    // first client looked at
	client_id_t grant_q;
	client_id_t pick;
	client_id_t idx;
	logic       locked;  // grant held until the latch

	// walk down so the client closest to prio wins
	always_comb
	begin
		pick = prio;
		idx = prio;
		for (int i = NUM_CLIENTS - 1; i >= 0; i--)
		begin
			idx = client_id_t'((int'(prio) + i) % NUM_CLIENTS);
			if (reqs[idx])
				pick = idx;
		end
	end

	assign grant = locked ? grant_q : pick;
	assign do_act = reqs[grant];
	assign sel_req = client_reqs[grant];

	always_comb
	begin
		for (int i = 0; i < NUM_CLIENTS; i++)
			latched_out[i] = latched && (grant == client_id_t'(i));
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			prio <= '0;
			grant_q <= '0;
			locked <= 1'b0;
		end
		else if (latched)
		begin
			locked <= 1'b0;
			prio <= (grant == client_id_t'(NUM_CLIENTS - 1)) ? '0 : grant + 1'b1;
		end
		else
		begin
			locked <= do_act;
			grant_q <= grant;
		end
	end

endmodule

`default_nettype wire

//--- client_pkg.sv
`default_nettype none

package client_pkg;

	localparam int NUM_CLIENTS = 2;
	localparam int REQ_ADDR_W  = 26; // row, bank, column
	localparam int DATA_W      = 32;

	typedef logic [$clog2(NUM_CLIENTS)-1:0] client_id_t;

	typedef struct packed {
		logic [REQ_ADDR_W-1:0] addr;
		logic                  we;
		logic [DATA_W-1:0]     wdata;
	} client_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
	} client_rsp_t;

endpackage

`default_nettype wire

//--- project.f
sdram_pkg.sv
client_pkg.sv
sdram_timing.sv
sdram_cmd_gen.sv
sdram_data_path.sv
client_arbiter.sv
sdram_ctrl_top.sv
tb_clock_gen.sv
tb_sdram_model.sv
tb_monitor.sv
sdram_ctrl_checker.sv
tb_sdram_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_sdram_ctrl -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0

//--- sdram_cmd_gen.sv
`default_nettype none

module sdram_cmd_gen
	import sdram_pkg::*;
	import client_pkg::*;
(
	input  wire              CLK,
	input  wire              RST,
	input  wire              do_act,
	input  wire client_req_t req,
	input  wire              change_possible,
	input  wire              page_open,
	input  wire              refresh_due,
	output sdram_cmd_e       command,
	output logic             change_requested,
	output logic             latched,
	output sdram_bus_t       bus,
	output logic             rd_issue,
	output logic             wr_issue
);

	logic [ROW_W-1:0]        row_live;
	logic [BANK_W-1:0]       bank_live;
	logic [COL_W-1:0]        col_live;
	logic [ADDR_W-1:0]       row_addr;
	logic [ADDR_W-1:0]       col_addr;
	logic [ROW_W+BANK_W-1:0] page_current; // row and bank of the open page
	logic [2:0]              actv_cnt;
	logic                    hold_met;
	logic                    refresh_reg;
	logic                    correct_page;
	logic                    latch_com;
	logic                    issue_buf;
	sdram_cmd_e              command_buf;  // next step toward the wanted page
	sdram_cmd_e              rw_command;

	assign row_live = req.addr[BANK_W+COL_W +: ROW_W];
	assign bank_live = req.addr[COL_W +: BANK_W];
	assign col_live = req.addr[0 +: COL_W];

	assign row_addr = {1'b0, row_live};
	assign col_addr = {col_live[COL_W-1:10], 1'b0, col_live[9:0]}; // A10 low, no auto-precharge

	assign hold_met = (actv_cnt >= ACTV_HOLD);
	assign correct_page = !refresh_due && page_open &&
		({row_live, bank_live} == page_current);
	assign latch_com = do_act && change_possible;
	assign rw_command = req.we ? WRTE : READ;

	// a refresh blocks new client steps until ARSR has gone out
	assign issue_buf = (do_act && !refresh_due) || refresh_reg;

	assign change_requested = correct_page ? do_act : issue_buf;
	assign command = correct_page ? rw_command : command_buf;
	assign latched = correct_page && latch_com;
	assign rd_issue = latched && !req.we;
	assign wr_issue = latched && req.we;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			command_buf <= NOOP;
			bus <= '{cmd: NOOP, bank: '0, addr: PRCH_ALL_ADDR};
			page_current <= '0;
			refresh_reg <= 1'b0;
			actv_cnt <= '0;
		end
		else
		begin
			refresh_reg <= refresh_due;

			if (!page_open)
				actv_cnt <= '0;
			else if (!hold_met)
				actv_cnt <= actv_cnt + 3'd1;

			if (correct_page)
			begin
				if (latch_com)
					bus <= '{cmd: rw_command, bank: bank_live, addr: col_addr};
				else
					bus.cmd <= NOOP;
			end
			else
			begin
				if (change_possible && issue_buf)
				begin
					bus.cmd <= command_buf;
					bus.bank <= bank_live;
					bus.addr <= (command_buf == ACTV) ? row_addr : PRCH_ALL_ADDR;
					if (command_buf == ACTV)
						page_current <= {row_live, bank_live};
				end
				else
					bus.cmd <= NOOP;

				if (page_open)
					command_buf <= hold_met ? PRCH : NOOP; // close the wrong page
				else
					command_buf <= refresh_due ? ARSR : ACTV;
			end
		end
	end

endmodule

`default_nettype wire

//--- sdram_ctrl_checker.sv
`default_nettype none

module sdram_ctrl_checker
	import sdram_pkg::*;
	import client_pkg::*;
(
	input wire                   CLK,
	input wire                   RST,
	input wire sdram_bus_t       bus,
	input wire                   latched,
	input wire                   we,
	input wire                   rd_valid,
	input wire                   page_open,
	input wire [NUM_CLIENTS-1:0] latched_out
);

	timeunit 1ns;
	timeprecision 1ps;

	// page_open rises on the same edge that puts ACTV on the bus
	actv_on_closed_page: assert property (@(posedge CLK) disable iff (!RST)
		bus.cmd == ACTV |-> !$past(page_open))
		else $error("ACTV issued while a page was open");

	rd_valid_after_read: assert property (@(posedge CLK) disable iff (!RST)
		rd_valid |-> $past(latched && !we, 3))
		else $error("rd_valid without a read latch three cycles before");

	// an accepted access keeps the next cycle free, for either client
	single_latch: assert property (@(posedge CLK) disable iff (!RST)
		latched_out != '0 |=> latched_out == '0)
		else $error("latch pulses on two cycles in a row");

endmodule

bind sdram_ctrl_top sdram_ctrl_checker u_checker (
	.CLK(CLK), .RST(RST), .bus(bus), .latched(latched), .we(sel_req.we),
	.rd_valid(rd_valid), .page_open(page_open), .latched_out(latched_out)
);

`default_nettype wire

//--- sdram_ctrl_top.sv
`default_nettype none

module sdram_ctrl_top
	import sdram_pkg::*;
	import client_pkg::*;
(
	input  wire                                CLK,
	input  wire                                RST,
	input  wire [NUM_CLIENTS-1:0]              reqs,
	input  wire client_req_t [NUM_CLIENTS-1:0] client_reqs,
	input  wire                                refresh_strobe,
	input  wire [DATA_W-1:0]                   dq_in,
	output logic [NUM_CLIENTS-1:0]             latched_out,
	output logic [NUM_CLIENTS-1:0]             rd_valid_out,
	output client_rsp_t                        rsp,
	output sdram_bus_t                         bus,
	output logic [DATA_W-1:0]                  dq_out,
	output logic                               dq_oe,
	output logic                               dm
);

	logic             do_act;
	client_req_t      sel_req;
	client_id_t       grant;
	client_id_t [2:0] grant_pipe; // grant at latch, carried to rd_valid
	logic             latched;
	sdram_cmd_e       command;
	logic             change_requested;
	logic             change_possible;
	logic             page_open;
	logic             refresh_due;
	logic             rd_issue;
	logic             wr_issue;
	logic             rd_valid;

	client_arbiter u_arbiter (
		.CLK(CLK), .RST(RST),
		.reqs(reqs), .client_reqs(client_reqs), .latched(latched),
		.do_act(do_act), .sel_req(sel_req), .grant(grant), .latched_out(latched_out)
	);

	sdram_cmd_gen u_cmd_gen (
		.CLK(CLK), .RST(RST),
		.do_act(do_act), .req(sel_req), .change_possible(change_possible),
		.page_open(page_open), .refresh_due(refresh_due),
		.command(command), .change_requested(change_requested), .latched(latched),
		.bus(bus), .rd_issue(rd_issue), .wr_issue(wr_issue)
	);

	sdram_timing u_timing (
		.CLK(CLK), .RST(RST),
		.change_requested(change_requested), .command(command),
		.refresh_strobe(refresh_strobe),
		.change_possible(change_possible), .state(),
		.page_open(page_open), .refresh_due(refresh_due)
	);

	sdram_data_path u_data_path (
		.CLK(CLK), .RST(RST),
		.rd_issue(rd_issue), .wr_issue(wr_issue), .wdata(sel_req.wdata), .dq_in(dq_in),
		.dq_out(dq_out), .dq_oe(dq_oe), .dm(dm), .rsp(rsp), .rd_valid(rd_valid)
	);

	always_ff @(posedge CLK)
		grant_pipe <= {grant_pipe[1:0], grant};

	always_comb
	begin
		for (int i = 0; i < NUM_CLIENTS; i++)
			rd_valid_out[i] = rd_valid && (grant_pipe[2] == client_id_t'(i));
	end

endmodule

`default_nettype wire

//--- sdram_data_path.sv
`default_nettype none

module sdram_data_path
	import client_pkg::*;
(
	input  wire              CLK,
	input  wire              RST,
	input  wire              rd_issue,
	input  wire              wr_issue,
	input  wire [DATA_W-1:0] wdata,
	input  wire [DATA_W-1:0] dq_in,
	output logic [DATA_W-1:0] dq_out,
	output logic             dq_oe,
	output logic             dm,
	output client_rsp_t      rsp,
	output logic             rd_valid
);

	logic [2:0] rd_pipe; // one bit per cycle since the read latch

	assign rd_valid = rd_pipe[2];

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_pipe <= '0;
			dq_oe <= 1'b0;
			dm <= 1'b1;
		end
		else
		begin
			rd_pipe <= {rd_pipe[1:0], rd_issue};
			dq_oe <= wr_issue; // same cycle as WRTE on the bus
			dm <= !wr_issue;
		end
	end

	// dq_in is sampled one cycle after READ is on the bus
	always_ff @(posedge CLK)
	begin
		if (wr_issue)
			dq_out <= wdata;
		if (rd_pipe[1])
			rsp.rdata <= dq_in;
	end

endmodule

`default_nettype wire

//--- sdram_pkg.sv
`default_nettype none

package sdram_pkg;

	// address field widths as seen on the client address
	localparam int ROW_W  = 12;
	localparam int BANK_W = 2;
	localparam int COL_W  = 12;
	localparam int ADDR_W = ROW_W + 1; // A12..A0 on the pins

	// command pin encoding
	typedef enum logic [2:0] {
		NOOP = 3'd0,
		ACTV = 3'd1,
		READ = 3'd2,
		WRTE = 3'd3,
		PRCH = 3'd4,
		ARSR = 3'd5
	} sdram_cmd_e;

	// spacing counter start values, one idle cycle per count
	localparam int SPACE_W = 4;
	localparam logic [SPACE_W-1:0] SPACE_ARSR = 4'd7; // refresh cycle time
	localparam logic [SPACE_W-1:0] SPACE_ACTV = 4'd3; // activate to access
	localparam logic [SPACE_W-1:0] SPACE_RW   = 4'd2;
	localparam logic [SPACE_W-1:0] SPACE_PRCH = 4'd3; // >= 2 so command_buf settles
	localparam logic [SPACE_W-1:0] SPACE_NOOP = 4'd1;

	localparam logic [2:0] ACTV_HOLD = 3'd4; // min cycles open before PRCH

	localparam logic [ADDR_W-1:0] PRCH_ALL_ADDR = 13'h0400; // A10 high

	// registered command pin group
	typedef struct packed {
		sdram_cmd_e        cmd;
		logic [BANK_W-1:0] bank;
		logic [ADDR_W-1:0] addr;
	} sdram_bus_t;

endpackage

`default_nettype wire

//--- sdram_timing.sv
`default_nettype none

module sdram_timing
	import sdram_pkg::*;
(
	input  wire             CLK,
	input  wire             RST,
	input  wire             change_requested,
	input  wire sdram_cmd_e command,
	input  wire             refresh_strobe,
	output logic            change_possible,
	output sdram_cmd_e      state,
	output logic            page_open,
	output logic            refresh_due
);

	logic [SPACE_W-1:0] counter;
	logic               second_stroke; // low on the cycle after an accept
	logic               beat_done;     // extra beat spent after counter expiry
	logic               miss_beat;     // last real command was WRTE
	logic               state_is_rw;
	logic               refresh_ack;
	logic               do_miss_beat;
	logic               cnt_ready;
	logic               fast_change;
	logic               accept;

	assign do_miss_beat = miss_beat && (command == PRCH);
	assign cnt_ready = (counter == '0) && (!do_miss_beat || beat_done);
	assign fast_change = state_is_rw && (command == state); // READ after READ etc
	assign change_possible = (cnt_ready || fast_change) && second_stroke;
	assign accept = change_possible && change_requested;
	assign refresh_due = refresh_ack ^ refresh_strobe;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= PRCH;
			page_open <= 1'b0;
			counter <= SPACE_PRCH;
			second_stroke <= 1'b0;
			beat_done <= 1'b0;
			miss_beat <= 1'b0;
			state_is_rw <= 1'b0;
			refresh_ack <= refresh_strobe; // nothing pending out of reset
		end
		else if (accept)
		begin
			state <= command;
			second_stroke <= 1'b0;
			beat_done <= 1'b0;
			state_is_rw <= (command == READ) || (command == WRTE);
			if (command != NOOP)
				miss_beat <= (command == WRTE);
			if (command == ACTV)
				page_open <= 1'b1;
			if (command == PRCH)
				page_open <= 1'b0;
			if (command == ARSR)
				refresh_ack <= refresh_strobe;

			case (command)
				ARSR: counter <= SPACE_ARSR;
				ACTV: counter <= SPACE_ACTV;
				READ,
				WRTE: counter <= SPACE_RW;
				PRCH: counter <= SPACE_PRCH;
				NOOP: counter <= SPACE_NOOP;
				default: counter <= SPACE_PRCH;
			endcase
		end
		else
		begin
			second_stroke <= 1'b1;
			if (counter != '0)
				counter <= counter - 4'd1;
			else
				beat_done <= 1'b1; // write recovery before PRCH
		end
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
(
	output logic CLK,
	output logic RST
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 8;

	initial
	begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	initial
	begin
		RST = 1'b0; // active low, held for the first cycles
		repeat (RESET_CYCLES) @(posedge CLK);
		RST <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tb_monitor.sv
`default_nettype none

module tb_monitor
	import sdram_pkg::*;
	import client_pkg::*;
(
	input  wire                                 CLK,
	input  wire                                 RST,
	input  wire [NUM_CLIENTS-1:0]               reqs,
	input  wire client_req_t [NUM_CLIENTS-1:0]  client_reqs,
	input  wire [NUM_CLIENTS-1:0][DATA_W-1:0]   exp_rdata,
	input  wire [NUM_CLIENTS-1:0][7:0]          test_id,
	input  wire                                 refresh_strobe,
	input  wire [NUM_CLIENTS-1:0]               latched_out,
	input  wire [NUM_CLIENTS-1:0]               rd_valid_out,
	input  wire client_rsp_t                    rsp,
	input  wire sdram_bus_t                     bus,
	input  wire [DATA_W-1:0]                    dq_out,
	input  wire                                 dq_oe,
	input  wire                                 dm,
	output int                                  errors,
	output int                                  tests_done,
	output int                                  tests_ok,
	output int                                  reads_pending,
	output int                                  refresh_pending
);

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct {
		int                    id;
		int                    client;
		logic                  we;
		logic [REQ_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     data;
		longint                due;
		bit                    bad;
	} access_t;

	access_t                 on_bus;       // latched last cycle, checked on the bus now
	bit                      on_bus_valid;
	access_t                 rq[$];        // reads waiting for rd_valid
	logic [DATA_W-1:0]       ref_mem [int];
	logic [ROW_W-1:0]        act_row [4];
	longint                  cycle;
	bit                      seen_req;
	bit                      prev_valid;
	bit                      prev_both;
	int                      prev_client;
	logic                    prev_strobe;
	bit                      pg_open;      // page state as seen on the bus
	logic [ROW_W+BANK_W-1:0] pg_key;
	bit                      miss_close;   // last PRCH was not for a refresh
	logic [ROW_W+BANK_W-1:0] closed_key;

	function automatic logic [DATA_W-1:0] fill_word(input logic [REQ_ADDR_W-1:0] a);
		return {a[5:0], a} ^ 32'h3C5A_96E1;
	endfunction

	function automatic bit check_hex(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got === exp)
			return 1'b0;
		$display("mismatch %s: expected %h, got %h", name, exp, got);
		errors++;
		return 1'b1;
	endfunction

	function automatic void plain_error(input string msg);
		$display("%s", msg);
		errors++;
	endfunction

	function automatic void finish_test(input access_t t);
		tests_done++;
		if (!t.bad)
			tests_ok++;
		$display("test %0d: client %0d %s at %h %s", t.id, t.client,
			t.we ? "write" : "read", t.addr, t.bad ? "failed" : "ok");
	endfunction

	always @(posedge CLK)
	begin
		access_t t;
		int      c;
		bit      both;
		if (!RST)
		begin
			errors = 0;
			tests_done = 0;
			tests_ok = 0;
			reads_pending = 0;
			refresh_pending = 0;
			on_bus_valid = 0;
			rq.delete();
			cycle = 0;
			seen_req = 0;
			prev_valid = 0;
			prev_both = 0;
			prev_strobe = refresh_strobe;
			pg_open = 0;
			miss_close = 0;
			for (int i = 0; i < 4; i++)
				act_row[i] = '0;
		end
		else
		begin
			cycle++;

			// quiet bus from reset until the first request
			if (!seen_req)
			begin
				if (reqs != '0)
					seen_req = 1;
				else if (bus.cmd != NOOP || latched_out != '0 || rd_valid_out != '0 || dq_oe)
				begin
					plain_error("SDRAM side active before the first request");
					seen_req = 1;
				end
			end

			// write data and mask only alongside WRTE
			void'(check_hex("dq_oe", 32'(dq_oe), 32'(bus.cmd == WRTE)));
			void'(check_hex("dm", 32'(dm), 32'(bus.cmd != WRTE)));

			if (bus.cmd == ARSR && pg_open)
				plain_error("ARSR issued while a page was open");
			if (bus.cmd == PRCH)
			begin
				miss_close = (refresh_pending == 0);
				closed_key = pg_key;
				pg_open = 0;
			end

			if (bus.cmd == ARSR)
			begin
				if (refresh_pending == 0)
					plain_error("ARSR on the bus without a refresh request");
				else
					refresh_pending--;
			end
			if ((bus.cmd == READ || bus.cmd == WRTE) && refresh_pending != 0)
				plain_error("access issued ahead of a pending refresh");
			if (refresh_strobe != prev_strobe)
				refresh_pending++;
			prev_strobe = refresh_strobe;

			// access command appears one cycle after its latch
			if (on_bus_valid)
			begin
				t = on_bus;
				on_bus_valid = 0;
				t.bad |= check_hex("bus.cmd", 32'(bus.cmd), t.we ? 32'(WRTE) : 32'(READ));
				t.bad |= check_hex("bus.bank", 32'(bus.bank), 32'(t.addr[13:12]));
				t.bad |= check_hex("bus.addr column", 32'({bus.addr[12:11], bus.addr[9:0]}),
					32'(t.addr[11:0]));
				t.bad |= check_hex("open row", 32'(act_row[bus.bank]), 32'(t.addr[25:14]));
				if (miss_close && closed_key == t.addr[REQ_ADDR_W-1:COL_W])
				begin
					plain_error("PRCH closed the page that the next access hits");
					t.bad = 1;
				end
				miss_close = 0;
				if (t.we)
				begin
					t.bad |= check_hex("dq_oe", 32'(dq_oe), 32'h1);
					t.bad |= check_hex("dq_out", dq_out, t.data);
					finish_test(t);
				end
				else
					rq.push_back(t);
			end
			if (bus.cmd == ACTV)
			begin
				act_row[bus.bank] = bus.addr[ROW_W-1:0];
				pg_open = 1;
				pg_key = {bus.addr[ROW_W-1:0], bus.bank};
			end

			if (rd_valid_out != '0)
			begin
				if (rq.size() == 0)
					plain_error("rd_valid with no read outstanding");
				else
				begin
					t = rq.pop_front();
					t.bad |= check_hex("rd_valid_out", 32'(rd_valid_out), 32'(1) << t.client);
					if (cycle != t.due)
					begin
						plain_error($sformatf("read data came %0d cycles after the latch",
							cycle - t.due + 3));
						t.bad = 1;
					end
					t.bad |= check_hex("rsp.rdata", rsp.rdata, t.data);
					finish_test(t);
				end
			end
			else if (rq.size() != 0 && cycle >= rq[0].due)
			begin
				t = rq.pop_front();
				plain_error($sformatf("no read data returned for test %0d", t.id));
				t.bad = 1;
				finish_test(t);
			end

			if (latched_out != '0)
			begin
				c = latched_out[1] ? 1 : 0;
				both = &reqs;
				if (both && prev_both && prev_valid && c == prev_client)
					plain_error($sformatf("client %0d latched twice while both requested", c));
				prev_both = both;
				prev_client = c;
				prev_valid = 1;
				t.id = int'(test_id[c]);
				t.client = c;
				t.we = client_reqs[c].we;
				t.addr = client_reqs[c].addr;
				t.bad = 0;
				t.due = cycle + 3;
				if (t.we)
				begin
					t.data = client_reqs[c].wdata;
					ref_mem[int'(t.addr)] = t.data;
				end
				else
				begin
					t.data = ref_mem.exists(int'(t.addr)) ? ref_mem[int'(t.addr)]
						: fill_word(t.addr);
					t.bad |= check_hex("expected rdata vs reference memory", t.data, exp_rdata[c]);
				end
				on_bus = t;
				on_bus_valid = 1;
			end

			reads_pending = rq.size() + ((on_bus_valid && !on_bus.we) ? 1 : 0);
		end
	end

endmodule

`default_nettype wire

//--- tb_sdram_ctrl.sv
`default_nettype none

module tb_sdram_ctrl
	import sdram_pkg::*;
	import client_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ENTRIES      = 18;
	localparam int CYCLES_PER_ENTRY = 60; // worst case miss plus refresh, with margin
	localparam int CLK_PERIOD       = 40;
	localparam int SEED             = 22;

	typedef struct {
		int                    client;
		bit                    we;
		logic [REQ_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     wdata;
		bit                    refresh; // toggle refresh_strobe before the request
		int                    src;     // entry whose write a read returns
		bit                    par;     // part of the contention phase
	} entry_t;

	logic                               CLK;
	logic                               RST;
	logic [NUM_CLIENTS-1:0]             reqs;
	client_req_t [NUM_CLIENTS-1:0]      client_reqs;
	logic                               refresh_strobe;
	logic [DATA_W-1:0]                  dq_in;
	logic [NUM_CLIENTS-1:0]             latched_out;
	logic [NUM_CLIENTS-1:0]             rd_valid_out;
	client_rsp_t                        rsp;
	sdram_bus_t                         bus;
	logic [DATA_W-1:0]                  dq_out;
	logic                               dq_oe;
	logic                               dm;
	logic [NUM_CLIENTS-1:0][DATA_W-1:0] exp_rdata;
	logic [NUM_CLIENTS-1:0][7:0]        test_id;
	int                                 errors;
	int                                 tests_done;
	int                                 tests_ok;
	int                                 reads_pending;
	int                                 refresh_pending;
	entry_t                             tbl [NUM_ENTRIES];
	int                                 n_entries;
	bit                                 fail;

	tb_clock_gen u_clock_gen (.CLK(CLK), .RST(RST));

	sdram_ctrl_top u_sdram_ctrl_top (
		.CLK(CLK), .RST(RST), .reqs(reqs), .client_reqs(client_reqs),
		.refresh_strobe(refresh_strobe), .dq_in(dq_in),
		.latched_out(latched_out), .rd_valid_out(rd_valid_out), .rsp(rsp), .bus(bus),
		.dq_out(dq_out), .dq_oe(dq_oe), .dm(dm)
	);

	tb_sdram_model u_sdram_model (
		.CLK(CLK), .bus(bus), .dq_out(dq_out), .dq_oe(dq_oe), .dm(dm), .dq_in(dq_in)
	);

	tb_monitor u_monitor (
		.CLK(CLK), .RST(RST), .reqs(reqs), .client_reqs(client_reqs),
		.exp_rdata(exp_rdata), .test_id(test_id), .refresh_strobe(refresh_strobe),
		.latched_out(latched_out), .rd_valid_out(rd_valid_out), .rsp(rsp), .bus(bus),
		.dq_out(dq_out), .dq_oe(dq_oe), .dm(dm), .errors(errors), .tests_done(tests_done),
		.tests_ok(tests_ok), .reads_pending(reads_pending), .refresh_pending(refresh_pending)
	);

	task automatic add_entry(input int c, input bit we, input int row, input int bank,
		input int col, input bit refresh, input int src, input bit par);
		tbl[n_entries].client = c;
		tbl[n_entries].we = we;
		tbl[n_entries].addr = {ROW_W'(row), BANK_W'(bank), COL_W'(col)};
		tbl[n_entries].wdata = we ? $urandom() : '0;
		tbl[n_entries].refresh = refresh;
		tbl[n_entries].src = src;
		tbl[n_entries].par = par;
		n_entries++;
	endtask

	task automatic build_table();
		n_entries = 0;
		add_entry(0, 1, 1, 0, 4, 0, -1, 0);       // write then read
		add_entry(0, 0, 1, 0, 4, 0, 0, 0);
		add_entry(1, 1, 1, 0, 8, 0, -1, 0);       // page hit
		add_entry(0, 1, 5, 0, 4, 0, -1, 0);       // other row, same bank
		add_entry(0, 0, 5, 0, 4, 0, 3, 0);        // hit, no PRCH
		add_entry(1, 0, 1, 0, 8, 0, 2, 0);        // back to the old row
		add_entry(0, 0, 1, 0, 4, 1, 0, 0);        // refresh with a page open
		add_entry(1, 1, 2, 1, 16, 0, -1, 0);
		add_entry(1, 0, 2, 1, 16, 0, 7, 0);
		add_entry(0, 1, 3, 2, 1, 0, -1, 1);       // both clients from here on
		add_entry(1, 1, 3, 2, 2, 0, -1, 1);
		add_entry(0, 0, 3, 2, 1, 0, 9, 1);
		add_entry(1, 0, 3, 2, 2, 0, 10, 1);
		add_entry(0, 1, 7, 3, 5, 0, -1, 1);
		add_entry(1, 0, 1, 0, 8, 0, 2, 1);
		add_entry(0, 0, 7, 3, 5, 0, 13, 1);
		add_entry(1, 1, 3, 2, 2, 0, -1, 1);
		add_entry(1, 0, 3, 2, 2, 0, 16, 1);
	endtask

	function automatic logic [DATA_W-1:0] expected_data(input int i);
		if (tbl[i].we || tbl[i].src < 0)
			return '0;
		return tbl[tbl[i].src].wdata;
	endfunction

	// called on a rising edge, returns on the edge that saw the latch
	task automatic apply_entry(input int i);
		int c;
		c = tbl[i].client;
		reqs[c] <= 1'b1;
		client_reqs[c] <= '{addr: tbl[i].addr, we: tbl[i].we, wdata: tbl[i].wdata};
		exp_rdata[c] <= expected_data(i);
		test_id[c] <= 8'(i);
		do
			@(posedge CLK);
		while (!latched_out[c]);
	endtask

	task automatic drive_client(input int c);
		for (int i = 0; i < n_entries; i++)
		begin
			if (tbl[i].par && tbl[i].client == c)
				apply_entry(i);
		end
		reqs[c] <= 1'b0;
	endtask

	initial
	begin
		reqs = '0;
		client_reqs = '0;
		refresh_strobe = 1'b0;
		exp_rdata = '0;
		test_id = '0;
		fail = 0;
		void'($urandom(SEED));
		build_table();
		wait (RST);
		repeat (4) @(posedge CLK); // reset state observed by the monitor

		for (int i = 0; i < n_entries; i++)
		begin
			if (!tbl[i].par)
			begin
				if (tbl[i].refresh)
				begin
					refresh_strobe <= ~refresh_strobe;
					repeat (2) @(posedge CLK);
				end
				apply_entry(i);
				reqs[tbl[i].client] <= 1'b0;
				@(posedge CLK);
			end
		end

		fork
			drive_client(0);
			drive_client(1);
		join

		do
			@(posedge CLK);
		while (reads_pending != 0);
		repeat (4) @(posedge CLK);

		if (refresh_pending != 0)
		begin
			$display("refresh request never produced an ARSR");
			fail = 1;
		end
		if (tests_done != n_entries)
		begin
			$display("only %0d of %0d tests finished", tests_done, n_entries);
			fail = 1;
		end
		$display("tests: %0d, passed: %0d, errors: %0d", tests_done, tests_ok, errors);
		if (errors == 0 && !fail)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#((8 + NUM_ENTRIES * CYCLES_PER_ENTRY) * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles",
			8 + NUM_ENTRIES * CYCLES_PER_ENTRY);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_sdram_model.sv
`default_nettype none

module tb_sdram_model
	import sdram_pkg::*;
	import client_pkg::*;
(
	input  wire              CLK,
	input  wire sdram_bus_t  bus,
	input  wire [DATA_W-1:0] dq_out,
	input  wire              dq_oe,
	input  wire              dm,
	output logic [DATA_W-1:0] dq_in
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [ROW_W-1:0]  open_row [4]; // row opened per bank by ACTV
	logic [DATA_W-1:0] mem [int];

	// unwritten words read back as a pattern of their own address
	function automatic logic [DATA_W-1:0] fill_word(input logic [REQ_ADDR_W-1:0] a);
		return {a[5:0], a} ^ 32'h3C5A_96E1;
	endfunction

	function automatic logic [REQ_ADDR_W-1:0] word_addr(input sdram_bus_t b);
		return {open_row[b.bank], b.bank, b.addr[12:11], b.addr[9:0]};
	endfunction

	initial
	begin
		dq_in = '0;
		for (int i = 0; i < 4; i++)
			open_row[i] = '0;
	end

	always @(posedge CLK)
	begin
		case (bus.cmd)
			ACTV: open_row[bus.bank] = bus.addr[ROW_W-1:0];
			WRTE:
			begin
				if (dq_oe && !dm)
					mem[int'(word_addr(bus))] = dq_out;
			end
			READ:
			begin
				if (mem.exists(int'(word_addr(bus))))
					dq_in <= mem[int'(word_addr(bus))];
				else
					dq_in <= fill_word(word_addr(bus));
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire
